// File: sources.f
+incdir+logic
logic/mem_pkg.sv
logic/dual_port_ram.sv
logic/data_lane_align.sv
logic/mem_subsystem.sv
tests/mem_subsystem_tb.sv

// File: Makefile
# Verilator build and run of the memory subsystem testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_subsystem_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

# Exit status of the simulation is the pass or fail result
test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/10ps

`include "mem_settings.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    // Random mix length and its region of 16 words
    localparam int         RANDOM_OPS = 200;
    localparam word_addr_t RAND_BASE  = 'h100;
    // Directed requests plus preload plus random mix
    localparam int         REQ_COUNT  = 60 + 16 + RANDOM_OPS;
    localparam int         TIMEOUT_NS = 4 * REQ_COUNT * 4 + 500;

    logic       clk;
    logic       rst_n;
    logic       fetch_en;
    byte_addr_t fetch_addr;
    word_t      fetch_data;
    logic       fetch_ready;
    logic       data_en;
    data_req_t  data_req;
    word_t      data_rdata;
    logic       data_ready;
    logic       data_misaligned;

    integer     seed = 32'hfb2abb1e;
    // Byte-wide model of the RAM contents
    logic [7:0] shadow [0:2**`MEM_BYTE_ADDR_BITS-1];

    mem_subsystem mem_subsystem_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_en        (fetch_en),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data),
        .fetch_ready     (fetch_ready),
        .data_en         (data_en),
        .data_req        (data_req),
        .data_rdata      (data_rdata),
        .data_ready      (data_ready),
        .data_misaligned (data_misaligned)
    );

    always #2 clk = ~clk;

    // ------------------------------------------------------------------------
    // Failure reporting and the checks
    // ------------------------------------------------------------------------

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        assert (got === expected) else begin
            $display("MISMATCH time=%0t %s got=%b expected=%b", $time, name, got, expected);
            abort_run();
        end
    endtask

    // Inputs change 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------------
    // Shadow model
    // ------------------------------------------------------------------------

    function automatic word_t shadow_word(input word_addr_t w);
        shadow_word = {shadow[{w, 2'd3}], shadow[{w, 2'd2}], shadow[{w, 2'd1}], shadow[{w, 2'd0}]};
    endfunction

    // Lane bytes taken from the low end of the store data
    task automatic apply_store(input byte_addr_t a, input access_size_t sz, input word_t wd);
        case (sz)
            `MEM_SIZE_BYTE: shadow[a] = wd[7:0];
            `MEM_SIZE_HALF: begin
                shadow[a]                = wd[7:0];
                shadow[{a[`MEM_BYTE_ADDR_BITS-1:1], 1'b1}] = wd[15:8];
            end
            default: begin
                shadow[{a[`MEM_BYTE_ADDR_BITS-1:2], 2'd0}] = wd[7:0];
                shadow[{a[`MEM_BYTE_ADDR_BITS-1:2], 2'd1}] = wd[15:8];
                shadow[{a[`MEM_BYTE_ADDR_BITS-1:2], 2'd2}] = wd[23:16];
                shadow[{a[`MEM_BYTE_ADDR_BITS-1:2], 2'd3}] = wd[31:24];
            end
        endcase
    endtask

    function automatic word_t expected_load(input byte_addr_t a, input access_size_t sz,
                                            input logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[{a[`MEM_BYTE_ADDR_BITS-1:1], 1'b1}], shadow[a]};
        case (sz)
            `MEM_SIZE_BYTE: expected_load = uns ? {24'b0, b} : {{24{b[7]}}, b};
            `MEM_SIZE_HALF: expected_load = uns ? {16'b0, h} : {{16{h[15]}}, h};
            default:        expected_load = shadow_word(a[`MEM_BYTE_ADDR_BITS-1:2]);
        endcase
    endfunction

    function automatic word_t fill_pattern(input word_addr_t w);
        fill_pattern = (word_t'(w) * 32'h9e3779b1) ^ 32'h5a5ac3c3;
    endfunction

    // ------------------------------------------------------------------------
    // Request drivers
    // ------------------------------------------------------------------------

    task automatic drive_data(input logic wr, input access_size_t sz, input logic uns,
                              input byte_addr_t a, input word_t wd);
        data_en              = 1'b1;
        data_req.addr        = a;
        data_req.wdata       = wd;
        data_req.size        = sz;
        data_req.is_unsigned = uns;
        data_req.write       = wr;
    endtask

    // One data request with ready in the next cycle only
    task automatic data_op(input logic wr, input access_size_t sz, input logic uns,
                           input byte_addr_t a, input word_t wd,
                           output word_t rdata, output logic mis);
        drive_data(wr, sz, uns, a, wd);
        step();
        data_en = 1'b0;
        check_flag("data_ready", data_ready, 1'b1);
        rdata = data_rdata;
        mis   = data_misaligned;
        step();
        check_flag("data_ready", data_ready, 1'b0);
    endtask

    task automatic store_and_track(input access_size_t sz, input byte_addr_t a, input word_t wd);
        word_t rd;
        logic  mis;
        data_op(1'b1, sz, 1'b0, a, wd, rd, mis);
        check_flag("data_misaligned", mis, 1'b0);
        apply_store(a, sz, wd);
    endtask

    task automatic load_and_check(input access_size_t sz, input logic uns, input byte_addr_t a);
        word_t rd;
        logic  mis;
        data_op(1'b0, sz, uns, a, 32'h0, rd, mis);
        check_flag("data_misaligned", mis, 1'b0);
        check_value("data_rdata", rd, expected_load(a, sz, uns));
    endtask

    task automatic fetch_and_check(input byte_addr_t a);
        fetch_en   = 1'b1;
        fetch_addr = a;
        step();
        fetch_en = 1'b0;
        check_flag("fetch_ready", fetch_ready, 1'b1);
        check_value("fetch_data", fetch_data, shadow_word(a[`MEM_BYTE_ADDR_BITS-1:2]));
        step();
        check_flag("fetch_ready", fetch_ready, 1'b0);
    endtask

    // Rejected access leaves memory alone
    task automatic misaligned_access(input logic wr, input access_size_t sz, input byte_addr_t a);
        word_t rd;
        logic  mis;
        data_op(wr, sz, 1'b0, a, 32'hcafef00d, rd, mis);
        check_flag("data_misaligned", mis, 1'b1);
        check_value("data_rdata", rd, 32'h0);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic reset_and_timing();
        check_flag("fetch_ready", fetch_ready, 1'b0);
        check_flag("data_ready", data_ready, 1'b0);
        check_flag("data_misaligned", data_misaligned, 1'b0);
        step();
        // No enable gives no ready
        check_flag("fetch_ready", fetch_ready, 1'b0);
        check_flag("data_ready", data_ready, 1'b0);
        drive_data(1'b1, `MEM_SIZE_WORD, 1'b0, 'h000, 32'h0badf00d);
        fetch_en   = 1'b1;
        fetch_addr = 'h004;
        step();
        data_en  = 1'b0;
        fetch_en = 1'b0;
        check_flag("fetch_ready", fetch_ready, 1'b1);
        check_flag("data_ready", data_ready, 1'b1);
        apply_store('h000, `MEM_SIZE_WORD, 32'h0badf00d);
        step();
        check_flag("fetch_ready", fetch_ready, 1'b0);
        check_flag("data_ready", data_ready, 1'b0);
    endtask

    task automatic word_store_load();
        store_and_track(`MEM_SIZE_WORD, 'h010, 32'hdeadbeef);
        store_and_track(`MEM_SIZE_WORD, 'hffc, 32'h01234567);
        load_and_check(`MEM_SIZE_WORD, 1'b0, 'h010);
        load_and_check(`MEM_SIZE_WORD, 1'b0, 'hffc);
        fetch_and_check('h010);
        fetch_and_check('hffc);
    endtask

    task automatic partial_stores();
        store_and_track(`MEM_SIZE_WORD, 'h040, 32'h11223344);
        // Upper data bits must not leak into other lanes
        store_and_track(`MEM_SIZE_BYTE, 'h041, 32'hffffffaa);
        store_and_track(`MEM_SIZE_HALF, 'h042, 32'h5555beef);
        fetch_and_check('h043);
        store_and_track(`MEM_SIZE_BYTE, 'h040, 32'h00000077);
        store_and_track(`MEM_SIZE_HALF, 'h040, 32'h00009cd1);
        fetch_and_check('h040);
    endtask

    task automatic load_extension();
        byte_addr_t base [2];
        base[0] = 'h0c0;
        base[1] = 'h0c4;
        // Mixed sign bits in every byte and half
        store_and_track(`MEM_SIZE_WORD, base[0], 32'h8a7fc315);
        store_and_track(`MEM_SIZE_WORD, base[1], 32'h7f8040ff);
        for (int k = 0; k < 2; k++) begin
            for (int off = 0; off < 4; off++) begin
                load_and_check(`MEM_SIZE_BYTE, 1'b0, base[k] | byte_addr_t'(off));
                load_and_check(`MEM_SIZE_BYTE, 1'b1, base[k] | byte_addr_t'(off));
            end
            load_and_check(`MEM_SIZE_HALF, 1'b0, base[k]);
            load_and_check(`MEM_SIZE_HALF, 1'b1, base[k]);
            load_and_check(`MEM_SIZE_HALF, 1'b0, base[k] | byte_addr_t'(2));
            load_and_check(`MEM_SIZE_HALF, 1'b1, base[k] | byte_addr_t'(2));
            load_and_check(`MEM_SIZE_WORD, 1'b0, base[k]);
        end
    endtask

    task automatic misaligned_cases();
        store_and_track(`MEM_SIZE_WORD, 'h080, 32'ha1b2c3d4);
        misaligned_access(1'b1, `MEM_SIZE_HALF, 'h081);
        misaligned_access(1'b1, `MEM_SIZE_HALF, 'h083);
        misaligned_access(1'b1, `MEM_SIZE_WORD, 'h082);
        misaligned_access(1'b0, `MEM_SIZE_WORD, 'h081);
        misaligned_access(1'b0, `MEM_SIZE_HALF, 'h083);
        load_and_check(`MEM_SIZE_WORD, 1'b0, 'h080);
        fetch_and_check('h080);
    endtask

    task automatic random_mix();
        integer       r;
        word_addr_t   w;
        access_size_t sz;
        logic [1:0]   off;
        byte_addr_t   a;
        byte_addr_t   fa;
        logic         wr;
        logic         uns;
        logic         fe;
        word_t        wd;
        word_t        exp_data;
        word_t        exp_fetch;
        for (int i = 0; i < 16; i++) begin
            w = RAND_BASE | word_addr_t'(i[3:0]);
            store_and_track(`MEM_SIZE_WORD, {w, 2'b00}, fill_pattern(w));
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r   = $random(seed);
            wd  = $random(seed);
            w   = RAND_BASE | word_addr_t'(r[3:0]);
            sz  = (r[5:4] == 2'd3) ? `MEM_SIZE_WORD : r[5:4];
            off = (sz == `MEM_SIZE_BYTE) ? r[7:6] :
                  (sz == `MEM_SIZE_HALF) ? {r[7], 1'b0} : 2'b00;
            a   = {w, off};
            wr  = r[8];
            uns = r[9];
            fe  = r[10];
            fa  = {RAND_BASE | word_addr_t'(r[14:11]), r[16:15]};
            // Fetch reads the word as it was before this cycle's store
            exp_fetch = shadow_word(fa[`MEM_BYTE_ADDR_BITS-1:2]);
            exp_data  = expected_load(a, sz, uns);
            if (wr) begin
                apply_store(a, sz, wd);
            end
            drive_data(wr, sz, uns, a, wd);
            fetch_en   = fe;
            fetch_addr = fa;
            step();
            check_flag("data_ready", data_ready, 1'b1);
            check_flag("data_misaligned", data_misaligned, 1'b0);
            check_flag("fetch_ready", fetch_ready, fe);
            if (!wr) begin
                check_value("data_rdata", data_rdata, exp_data);
            end
            if (fe) begin
                check_value("fetch_data", fetch_data, exp_fetch);
            end
        end
        data_en  = 1'b0;
        fetch_en = 1'b0;
        step();
        check_flag("data_ready", data_ready, 1'b0);
        check_flag("fetch_ready", fetch_ready, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        // Requests held through reset must leave no ready behind
        fetch_en   = 1'b1;
        fetch_addr = '0;
        data_en    = 1'b1;
        data_req   = '0;
        // Misaligned word load drives the pending flag
        data_req.size = `MEM_SIZE_WORD;
        data_req.addr = 'h001;
        repeat (4) @(posedge clk);
        #1;
        rst_n    = 1'b1;
        fetch_en = 1'b0;
        data_en  = 1'b0;
        data_req = '0;
        reset_and_timing();
        word_store_load();
        partial_stores();
        load_extension();
        misaligned_cases();
        random_mix();
        $display("Verification passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
        abort_run();
    end

endmodule

// File: logic/mem_subsystem.sv
`timescale 1ns/10ps

`include "mem_settings.svh"

module mem_subsystem
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Instruction fetch, whole words only
    input  logic       fetch_en,
    input  byte_addr_t fetch_addr,
    output word_t      fetch_data,
    output logic       fetch_ready,

    // Loads and stores
    input  logic       data_en,
    input  data_req_t  data_req,
    output word_t      data_rdata,
    output logic       data_ready,
    output logic       data_misaligned
);

    // ---------------------------------------------------------------------------
    // Aligner to RAM port B
    // ---------------------------------------------------------------------------

    logic     ram_b_en;
    ram_req_t ram_b_req;
    word_t    b_rdata;
    logic     b_ready;

    data_lane_align data_lane_align_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_en         (data_en),
        .data_req        (data_req),
        .data_rdata      (data_rdata),
        .data_ready      (data_ready),
        .data_misaligned (data_misaligned),
        .ram_b_en        (ram_b_en),
        .ram_b_req       (ram_b_req),
        .b_rdata         (b_rdata),
        .b_ready         (b_ready)
    );

    // Fetch drops the lane bits on its way to port A
    dual_port_ram dual_port_ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_en    (fetch_en),
        .a_addr  (fetch_addr[`MEM_BYTE_ADDR_BITS-1:2]),
        .a_rdata (fetch_data),
        .a_ready (fetch_ready),
        .b_en    (ram_b_en),
        .b_req   (ram_b_req),
        .b_rdata (b_rdata),
        .b_ready (b_ready)
    );

endmodule

// File: logic/data_lane_align.sv
`timescale 1ns/10ps

`include "mem_settings.svh"

module data_lane_align
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // Core side
    input  logic      data_en,
    input  data_req_t data_req,
    output word_t     data_rdata,
    output logic      data_ready,
    output logic      data_misaligned,

    // RAM port B side
    output logic      ram_b_en,
    output ram_req_t  ram_b_req,
    input  word_t     b_rdata,
    input  logic      b_ready
);

    // Byte offset inside the addressed word
    logic [1:0] req_offset;
    // Request crosses a word boundary
    logic       req_misaligned;
    // Lane mask for a store
    byte_en_t   lane_mask;
    // Store data copied into every lane it could land in
    word_t      wdata_rep;

    // Context for the returning load
    load_ctx_t  ctx_q;
    logic       pend_misaligned_q;

    // Read data moved down to bit 0
    word_t      rdata_shifted;
    // Extended load result
    word_t      rdata_ext;

    // -----------------------------------------------------------------------
    // Request side
    // -----------------------------------------------------------------------

    assign req_offset = data_req.addr[1:0];

    always_comb begin
        req_misaligned = 1'b0;
        lane_mask      = 4'b1111;
        wdata_rep      = data_req.wdata;
        case (data_req.size)
            `MEM_SIZE_BYTE: begin
                lane_mask = 4'b0001 << req_offset;
                wdata_rep = {4{data_req.wdata[7:0]}};
            end
            `MEM_SIZE_HALF: begin
                // Odd address spills into the next lane pair
                req_misaligned = req_offset[0];
                lane_mask      = 4'b0011 << req_offset;
                wdata_rep      = {2{data_req.wdata[15:0]}};
            end
            default: begin
                // Word, and the unused code treated the same way
                req_misaligned = (req_offset != 2'b00);
            end
        endcase
    end

    // Misaligned requests never reach the RAM
    assign ram_b_en          = data_en & ~req_misaligned;
    assign ram_b_req.addr    = data_req.addr[`MEM_BYTE_ADDR_BITS-1:2];
    // Loads go out with no lanes enabled
    assign ram_b_req.byte_en = data_req.write ? lane_mask : 4'b0000;
    assign ram_b_req.wdata   = wdata_rep;

    // -----------------------------------------------------------------------
    // Held across the RAM latency
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_misaligned_q <= 1'b0;
        end else begin
            pend_misaligned_q <= data_en & req_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (data_en) begin
            ctx_q.offset      <= req_offset;
            ctx_q.size        <= data_req.size;
            ctx_q.is_unsigned <= data_req.is_unsigned;
        end
    end

    // -----------------------------------------------------------------------
    // Answer side
    // -----------------------------------------------------------------------

    // Offset in bytes times eight gives the bit shift
    assign rdata_shifted = b_rdata >> {ctx_q.offset, 3'b000};

    always_comb begin
        case (ctx_q.size)
            `MEM_SIZE_BYTE: begin
                rdata_ext = ctx_q.is_unsigned ? {24'b0, rdata_shifted[7:0]}
                                              : {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
            end
            `MEM_SIZE_HALF: begin
                rdata_ext = ctx_q.is_unsigned ? {16'b0, rdata_shifted[15:0]}
                                              : {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
            end
            default: begin
                rdata_ext = rdata_shifted;
            end
        endcase
    end

    // Zero data on a rejected access
    assign data_rdata      = pend_misaligned_q ? '0 : rdata_ext;
    assign data_ready      = b_ready | pend_misaligned_q;
    assign data_misaligned = pend_misaligned_q;

endmodule

// File: logic/dual_port_ram.sv
`timescale 1ns/10ps

`include "mem_settings.svh"

module dual_port_ram
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // Port A, instruction fetch, read only
    input  logic       a_en,
    input  word_addr_t a_addr,
    output word_t      a_rdata,
    output logic       a_ready,

    // Port B, data, byte-enabled read/write
    input  logic       b_en,
    input  ram_req_t   b_req,
    output word_t      b_rdata,
    output logic       b_ready
);

    // Number of words in the array
    localparam int DEPTH = 2 ** `MEM_WORD_ADDR_BITS;
    // Byte lanes per word
    localparam int LANES = $bits(byte_en_t);

    // Word storage
    word_t mem [0:DEPTH-1];

    // -----------------------------------------------------------------------
    // Ready pulses, one cycle behind the enable
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_ready <= 1'b0;
            b_ready <= 1'b0;
        end else begin
            a_ready <= a_en;
            b_ready <= b_en;
        end
    end

    // -----------------------------------------------------------------------
    // Port A
    // -----------------------------------------------------------------------

    // Registered read, sees the old word on a same-cycle port B write
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
        end
    end

    // -----------------------------------------------------------------------
    // Port B
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (b_en) begin
            // Only lanes with their enable set are written
            for (int lane = 0; lane < LANES; lane++) begin
                if (b_req.byte_en[lane]) begin
                    mem[b_req.addr][lane*8 +: 8] <= b_req.wdata[lane*8 +: 8];
                end
            end
            // Don't care on a write cycle
            b_rdata <= mem[b_req.addr];
        end
    end

endmodule

// File: logic/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

    // -----------------------------------------------------------------------
    // Plain vectors with a meaning
    // -----------------------------------------------------------------------

    // One data word
    typedef logic [31:0] word_t;
    // Byte-lane write enables, bit 0 is bits 7:0
    typedef logic [3:0] byte_en_t;
    // Address counted in words
    typedef logic [`MEM_WORD_ADDR_BITS-1:0] word_addr_t;
    // Address counted in bytes
    typedef logic [`MEM_BYTE_ADDR_BITS-1:0] byte_addr_t;
    // Holds one of the MEM_SIZE_* codes
    typedef logic [1:0] access_size_t;

    // -----------------------------------------------------------------------
    // Bundles
    // -----------------------------------------------------------------------

    // Data-port request from the core
    typedef struct packed {
        byte_addr_t   addr;
        word_t        wdata;
        access_size_t size;
        // Zero-extend loads when set
        logic         is_unsigned;
        logic         write;
    } data_req_t;

    // Word-level request into RAM port B
    typedef struct packed {
        word_addr_t addr;
        // All zero means a read
        byte_en_t   byte_en;
        word_t      wdata;
    } ram_req_t;

    // Kept until the read data comes back
    typedef struct packed {
        logic [1:0]   offset;
        access_size_t size;
        logic         is_unsigned;
    } load_ctx_t;

endpackage

// File: logic/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Memory geometry
// ---------------------------------------------------------------------------

// Word address width, RAM holds 2**N words
`define MEM_WORD_ADDR_BITS 10

// Byte address adds the two lane-select bits
`define MEM_BYTE_ADDR_BITS (`MEM_WORD_ADDR_BITS + 2)

// ---------------------------------------------------------------------------
// Access-size codes on the data port
// ---------------------------------------------------------------------------

`define MEM_SIZE_BYTE 2'd0
`define MEM_SIZE_HALF 2'd1
`define MEM_SIZE_WORD 2'd2

`endif
